// ==== tb.f ====
kiwi_gfx_pkg.sv
gfx_dual_ram.sv
gfx_line_buffer.sv
gfx_tilemap.sv
gfx_obj.sv
kiwi_gfx.sv
tb_kiwi_gfx_asserts.sv
tb_kiwi_gfx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the kiwi_gfx testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kiwi_gfx -f tb.f --Mdir obj_dir -o vtb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/vtb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tb_kiwi_gfx.sv ====
`timescale 1ns/1ps

module tb_kiwi_gfx import kiwi_gfx_pkg::*; ();

    localparam int    OBJ_COUNT  = 16;
    localparam int    FRAMES     = 6;
    localparam longint FRAME_NS  = 264 * 320 * 4 * 10;
    localparam longint WATCHDOG_NS = (FRAMES + 2) * FRAME_NS;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen, hs;
    hpos_t       hdump, vdump, vrender;
    logic        cpu_rnw, vram_cs, vctrl_cs;
    logic [12:0] cpu_addr;
    logic [7:0]  cpu_dout, cpu_din;
    logic        flip;
    rom_addr_t   scr_addr, obj_addr;
    rom_word_t   scr_data, obj_data;
    logic        scr_ok, obj_ok, scr_cs, obj_cs;
    pxl_t        scr_pxl, obj_pxl;

    // shadow state of the DUT memories
    vram_word_t  vram_sh [0:4095];
    logic [7:0]  yram_sh [0:1023];
    logic [7:0]  cfg0_sh, cfg1_sh;
    rom_word_t   scr_rom [0:32767];
    rom_word_t   obj_rom [0:32767];
    // effective line in the front half, and the one being drawn
    logic [7:0]  disp_ln, pend_ln;
    int          frame_cnt, div;

    always #5 clk = ~clk;

    kiwi_gfx #(.OBJ_COUNT(OBJ_COUNT)) UUT (.*);

    task automatic compare_values(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("ERROR time %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic write_vram(input logic [12:0] a, input logic [7:0] d);
        vram_cs = 1'b1;
        cpu_rnw = 1'b0;
        cpu_addr = a;
        cpu_dout = d;
        @(posedge clk);
        #1 vram_cs = 1'b0;
        if (a[12]) vram_sh[a[11:0]][15:8] = d;
        else vram_sh[a[11:0]][7:0] = d;
    endtask

    task automatic write_ctrl(input logic [9:0] a, input logic [7:0] d);
        vctrl_cs = 1'b1;
        cpu_rnw = 1'b0;
        cpu_addr = {3'b000, a};
        cpu_dout = d;
        @(posedge clk);
        #1 vctrl_cs = 1'b0;
        if (a[9:8] != 2'd3) yram_sh[a] = d;
        else if (a[1:0] == 2'd0) cfg0_sh = d;
        else if (a[1:0] == 2'd1) cfg1_sh = d;
    endtask

    // one read strobe, data due on the next clock
    task automatic read_back(input logic ctrl, input logic [12:0] a);
        logic [7:0] exp;
        vram_cs = ~ctrl;
        vctrl_cs = ctrl;
        cpu_rnw = 1'b1;
        cpu_addr = a;
        @(posedge clk);
        #1 vram_cs = 1'b0;
        vctrl_cs = 1'b0;
        if (ctrl) exp = yram_sh[a[9:0]];
        else exp = a[12] ? vram_sh[a[11:0]][15:8] : vram_sh[a[11:0]][7:0];
        compare_values("cpu_din", cpu_din, exp);
    endtask

    function automatic pxl_t model_scr_pixel(input logic [7:0] ln, input int h);
        logic [7:0] sum;
        logic [4:0] c;
        vram_word_t w;
        logic [3:0] v;
        c = h[7:3];
        sum = ln + yram_sh[SCROLL_BASE + c];
        w = vram_sh[(cfg1_sh[6] ? 12'h400 : 12'h000) + {sum[7:3], c}];
        v = scr_rom[{w[11:0], sum[2:0]}][4*h[2:0] +: 4];
        return (v == 4'd0) ? 8'h00 : {w[15:12], v};
    endfunction

    // first object with an opaque pixel wins
    function automatic pxl_t model_obj_pixel(input logic [7:0] ln, input int h);
        logic [7:0] d, x;
        vram_word_t w;
        logic [3:0] v;
        for (int i = 0; i < OBJ_COUNT; i++) begin
            d = ln - yram_sh[OBJ_Y_BASE + i];
            x = yram_sh[OBJ_X_BASE + i];
            if (d < 8 && h >= x && h - x < 8) begin
                w = vram_sh[OBJ_BASE + (cfg1_sh[5] ? 12'h400 : 12'h000) + i];
                v = obj_rom[{w[11:0], d[2:0]}][4*(h - x) +: 4];
                if (v != 4'd0) return {w[15:12], v};
            end
        end
        return 8'h00;
    endfunction

    // video timing, pxl_cen every fourth clock
    initial begin
        pxl_cen = 1'b0;
        hs = 1'b0;
        hdump = '0;
        vdump = '0;
        vrender = 9'd1;
        div = 0;
        frame_cnt = 0;
        disp_ln = '0;
        pend_ln = '0;
        forever begin
            @(posedge clk);
            #1;
            if (pxl_cen) begin
                if (hdump == 9'd319) begin
                    hdump = '0;
                    vdump = (vdump == 9'd263) ? 9'd0 : vdump + 9'd1;
                    vrender = (vdump == 9'd263) ? 9'd0 : vdump + 9'd1;
                    if (vdump == 9'd0) frame_cnt++;
                end else begin
                    hdump = hdump + 9'd1;
                end
                // renderers latch their line on the hs edge
                if (hdump == 9'd300) begin
                    disp_ln = pend_ln;
                    pend_ln = vrender[7:0] ^ {8{cfg0_sh[6]}};
                end
                hs = hdump >= 9'd300 && hdump <= 9'd311;
            end
            div = (div + 1) % 4;
            pxl_cen = div == 0;
        end
    end

    // ROM models, ok after 1 to 6 clocks
    initial begin
        scr_ok = 1'b0;
        scr_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (scr_cs) begin
                repeat ($urandom % 6 + 1) @(posedge clk);
                #1 scr_ok = 1'b1;
                scr_data = scr_rom[scr_addr[14:0]];
                @(posedge clk);
                #1 scr_ok = 1'b0;
            end
        end
    end

    initial begin
        obj_ok = 1'b0;
        obj_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (obj_cs) begin
                repeat ($urandom % 6 + 1) @(posedge clk);
                #1 obj_ok = 1'b1;
                obj_data = obj_rom[obj_addr[14:0]];
                @(posedge clk);
                #1 obj_ok = 1'b0;
            end
        end
    end

    // pixel samples, stable in the clock after pxl_cen
    initial begin
        int h;
        int v;
        int f;
        pxl_t es, eo;
        forever begin
            @(posedge clk);
            if (pxl_cen) begin
                h = hdump;
                v = vdump;
                f = frame_cnt;
                @(negedge clk);
                // lines drawn while the cpu is quiet
                if (f >= 1 && v <= 229) begin
                    es = (h < LINE_W && cfg0_sh[4]) ? model_scr_pixel(disp_ln, h) : 8'h00;
                    eo = (h < LINE_W && cfg0_sh[4]) ? model_obj_pixel(disp_ln, h) : 8'h00;
                    compare_values("scr_pxl", scr_pxl, es);
                    compare_values("obj_pxl", obj_pxl, eo);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the last frame finished");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        int k;
        int idx;
        void'($urandom(64));
        rst = 1'b1;
        cpu_rnw = 1'b1;
        vram_cs = 1'b0;
        vctrl_cs = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        cfg0_sh = '0;
        cfg1_sh = '0;
        for (int i = 0; i < 32768; i++) begin
            scr_rom[i] = $urandom;
            obj_rom[i] = $urandom;
        end
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        // fill both RAMs through the cpu port
        for (int a = 0; a < 8192; a++) begin
            write_vram(13'(a), 8'($urandom));
        end
        for (int a = 0; a < 768; a++) begin
            write_ctrl(10'(a), 8'($urandom));
        end
        for (int i = 0; i < 300; i++) begin
            k = $urandom % 2;
            if (k == 1) read_back(1'b1, 13'($urandom % 768));
            else read_back(1'b0, 13'($urandom));
        end
        write_ctrl(10'h300, 8'h10);
        for (int f = 0; f < FRAMES - 1; f++) begin
            wait (frame_cnt == f && vdump == 9'd230);
            @(posedge clk);
            #1;
            for (int i = 0; i < 60; i++) begin
                idx = $urandom % OBJ_COUNT;
                case ($urandom % 6)
                    0: write_vram(13'($urandom % 2048) | 13'(($urandom % 2) << 12),
                                  8'($urandom));
                    1: write_vram(13'(OBJ_BASE + ($urandom % 2) * 1024 + idx) |
                                  13'(($urandom % 2) << 12), 8'($urandom));
                    2: write_ctrl(SCROLL_BASE + 10'($urandom % 32), 8'($urandom));
                    3: write_ctrl(OBJ_Y_BASE + 10'(idx), 8'($urandom));
                    // overlap with the previous object
                    4: write_ctrl(OBJ_Y_BASE + 10'(idx),
                                  yram_sh[OBJ_Y_BASE + (idx + OBJ_COUNT - 1) % OBJ_COUNT]);
                    default: write_ctrl(OBJ_X_BASE + 10'(idx), ($urandom % 2) ?
                                        8'(248 + $urandom % 8) : 8'($urandom));
                endcase
            end
            // flip in frame 3, video off in frame 4
            if (f == 2) write_ctrl(10'h300, 8'h50);
            else if (f == 3) write_ctrl(10'h300, 8'h00);
            else write_ctrl(10'h300, 8'h10);
            compare_values("flip", flip, cfg0_sh[6]);
            write_ctrl(10'h301, 8'($urandom) & 8'h60);
        end
        wait (frame_cnt == FRAMES);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== tb_kiwi_gfx_asserts.sv ====
`timescale 1ns/1ps

module tb_kiwi_gfx_asserts import kiwi_gfx_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      scr_cs,
    input logic      scr_ok,
    input rom_addr_t scr_addr,
    input logic      obj_cs,
    input logic      obj_ok,
    input rom_addr_t obj_addr,
    input logic      video_en,
    input pxl_t      scr_pxl,
    input pxl_t      obj_pxl
);

    // request held with a steady address until ok
    scr_hold: assert property (@(posedge clk) disable iff (rst)
        scr_cs && !scr_ok |=> scr_cs && $stable(scr_addr))
        else $error("scr request changed before ok");
    obj_hold: assert property (@(posedge clk) disable iff (rst)
        obj_cs && !obj_ok |=> obj_cs && $stable(obj_addr))
        else $error("obj request changed before ok");

    // cs falls right after ok
    scr_drop: assert property (@(posedge clk) disable iff (rst)
        scr_cs && scr_ok |=> !scr_cs)
        else $error("scr cs held after ok");
    obj_drop: assert property (@(posedge clk) disable iff (rst)
        obj_cs && obj_ok |=> !obj_cs)
        else $error("obj cs held after ok");

    blank_off: assert property (@(posedge clk) disable iff (rst)
        !video_en |-> scr_pxl == 8'h00 && obj_pxl == 8'h00)
        else $error("pixels out with video off");

endmodule

bind kiwi_gfx tb_kiwi_gfx_asserts u_asserts (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .scr_cs   ( scr_cs   ),
    .scr_ok   ( scr_ok   ),
    .scr_addr ( scr_addr ),
    .obj_cs   ( obj_cs   ),
    .obj_ok   ( obj_ok   ),
    .obj_addr ( obj_addr ),
    .video_en ( video_en ),
    .scr_pxl  ( scr_pxl  ),
    .obj_pxl  ( obj_pxl  )
);

// ==== kiwi_gfx.sv ====
`timescale 1ns/1ps

module kiwi_gfx import kiwi_gfx_pkg::*; #(
    parameter int OBJ_COUNT = 16
) (
    input  logic        clk,
    input  logic        rst,
    // video timing
    input  logic        pxl_cen,
    input  logic        hs,
    input  hpos_t       hdump,
    input  hpos_t       vdump,
    input  hpos_t       vrender,
    // cpu bus
    input  logic        cpu_rnw,
    input  logic [12:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        vram_cs,
    input  logic        vctrl_cs,
    output logic [7:0]  cpu_din,
    output logic        flip,
    // tilemap ROM
    output rom_addr_t   scr_addr,
    input  rom_word_t   scr_data,
    input  logic        scr_ok,
    output logic        scr_cs,
    // object ROM
    output rom_addr_t   obj_addr,
    input  rom_word_t   obj_data,
    input  logic        obj_ok,
    output logic        obj_cs,
    // to the mixer
    output pxl_t        scr_pxl,
    output pxl_t        obj_pxl
);

    logic       yram_cs, cfg_cs, yram_we;
    logic [1:0] vram_we;
    logic [7:0] cfg0, cfg1;
    logic       video_en, tm_page, obj_page;
    // cpu read pipeline
    logic       rd_vram, rd_yram, rd_hi;
    vram_word_t vram_q, code_q;
    logic [7:0] yram_q, col_q;
    // four slot sharing of the port B side
    logic [1:0] slot;
    logic       tm_cen, lut_cen;
    vram_addr_t tm_addr, lut_addr, code_addr;
    yram_addr_t col_addr, y_addr, yb_addr;
    pxl_t       scr_raw, obj_raw;
    logic       vis;

    // control space, 0..2 column RAM and 3 registers
    assign yram_cs  = vctrl_cs & (cpu_addr[9:8] != 2'd3);
    assign cfg_cs   = vctrl_cs & (cpu_addr[9:8] == 2'd3);
    // bit 12 picks the byte lane
    assign vram_we  = {2{vram_cs & ~cpu_rnw}} & {cpu_addr[12], ~cpu_addr[12]};
    assign yram_we  = yram_cs & ~cpu_rnw;

    assign flip     = cfg0[6];
    assign video_en = cfg0[4];
    assign tm_page  = cfg1[6];
    assign obj_page = cfg1[5];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg0    <= '0;
            cfg1    <= '0;
            rd_vram <= 1'b0;
            rd_yram <= 1'b0;
            rd_hi   <= 1'b0;
            slot    <= '0;
            vis     <= 1'b0;
        end else begin
            // registers 2 and 3 take writes and keep nothing
            if (cfg_cs && !cpu_rnw) begin
                case (cpu_addr[1:0])
                    2'd0: cfg0 <= cpu_dout;
                    2'd1: cfg1 <= cpu_dout;
                    default: ;
                endcase
            end
            // remember what was read for the data clock
            rd_vram <= vram_cs & cpu_rnw;
            rd_yram <= yram_cs & cpu_rnw;
            rd_hi   <= cpu_addr[12];
            slot    <= slot + 2'd1;
            if (pxl_cen) begin
                vis <= hdump < hpos_t'(LINE_W);
            end
        end
    end

    // config reads return zero
    assign cpu_din = rd_vram ? (rd_hi ? vram_q[15:8] : vram_q[7:0]) :
                     rd_yram ? yram_q : 8'h00;

    assign tm_cen    = slot == 2'd0;
    assign lut_cen   = slot == 2'd2;
    // slots 0,1 tilemap, slots 2,3 objects
    assign code_addr = slot[1] ? lut_addr : tm_addr;
    assign yb_addr   = slot[1] ? y_addr : col_addr;

    // blank past the visible width and with video off
    assign scr_pxl = (vis && video_en) ? scr_raw : '0;
    assign obj_pxl = (vis && video_en) ? obj_raw : '0;

    gfx_dual_ram #(.AW(12), .DW(16)) u_vram (
        .clk   ( clk              ),
        .addr0 ( cpu_addr[11:0]   ),
        .data0 ( {2{cpu_dout}}    ),
        .we0   ( vram_we          ),
        .q0    ( vram_q           ),
        .addr1 ( code_addr        ),
        .q1    ( code_q           )
    );

    gfx_dual_ram #(.AW(10), .DW(8)) u_yram (
        .clk   ( clk              ),
        .addr0 ( cpu_addr[9:0]    ),
        .data0 ( cpu_dout         ),
        .we0   ( yram_we          ),
        .q0    ( yram_q           ),
        .addr1 ( yb_addr          ),
        .q1    ( col_q            )
    );

    gfx_tilemap u_tilemap (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .tm_cen   ( tm_cen   ),
        .hs       ( hs       ),
        .flip     ( flip     ),
        .page     ( tm_page  ),
        .vrender  ( vrender  ),
        .tm_addr  ( tm_addr  ),
        .tm_data  ( code_q   ),
        .col_addr ( col_addr ),
        .col_data ( col_q    ),
        .rom_addr ( scr_addr ),
        .rom_cs   ( scr_cs   ),
        .rom_ok   ( scr_ok   ),
        .rom_data ( scr_data ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .pxl      ( scr_raw  )
    );

    // same flip sense as the tilemap
    gfx_obj #(.OBJ_COUNT(OBJ_COUNT)) u_obj (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .lut_cen  ( lut_cen  ),
        .hs       ( hs       ),
        .flip     ( flip     ),
        .page     ( obj_page ),
        .vrender  ( vrender  ),
        .lut_addr ( lut_addr ),
        .lut_data ( code_q   ),
        .y_addr   ( y_addr   ),
        .y_data   ( col_q    ),
        .rom_addr ( obj_addr ),
        .rom_cs   ( obj_cs   ),
        .rom_ok   ( obj_ok   ),
        .rom_data ( obj_data ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .pxl      ( obj_raw  )
    );

endmodule

// ==== gfx_obj.sv ====
`timescale 1ns/1ps

module gfx_obj import kiwi_gfx_pkg::*; #(
    parameter int OBJ_COUNT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       lut_cen,
    input  logic       hs,
    input  logic       flip,
    input  logic       page,
    input  hpos_t      vrender,
    // object codes
    output vram_addr_t lut_addr,
    input  vram_word_t lut_data,
    // object y and x
    output yram_addr_t y_addr,
    input  logic [7:0] y_data,
    // graphics ROM
    output rom_addr_t  rom_addr,
    output logic       rom_cs,
    input  logic       rom_ok,
    input  rom_word_t  rom_data,
    // display side
    input  logic       pxl_cen,
    input  hpos_t      hdump,
    output pxl_t       pxl
);

    localparam int IW = (OBJ_COUNT > 1) ? $clog2(OBJ_COUNT) : 1;

    typedef enum logic [2:0] {
        OB_IDLE,
        OB_READ_Y,
        OB_READ_X,
        OB_CODE,
        OB_FETCH,
        OB_DRAW,
        OB_NEXT
    } obj_state_t;

    obj_state_t    state;
    logic          hs_l, swap;
    logic [1:0]    cen_sr;
    logic          issued, issue, ram_rdy;
    logic [IW-1:0] idx;
    logic [2:0]    nib, row;
    logic [7:0]    line, xpos, dy;
    logic [8:0]    xn;
    logic [3:0]    colour;
    rom_word_t     pix;

    assign swap    = hs & ~hs_l;
    assign issue   = lut_cen & ~issued;
    assign ram_rdy = cen_sr[1] & issued;
    // line inside the object, wraps at 256
    assign dy      = line - y_data;
    // screen x of the pixel being drawn
    assign xn      = {1'b0, xpos} + 9'(nib);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= OB_IDLE;
            hs_l   <= 1'b0;
            cen_sr <= '0;
            issued <= 1'b0;
            rom_cs <= 1'b0;
            idx    <= '0;
            nib    <= '0;
        end else begin
            hs_l   <= hs;
            cen_sr <= {cen_sr[0], lut_cen};
            case (state)
                OB_READ_Y, OB_READ_X, OB_CODE: begin
                    if (issue) begin
                        issued <= 1'b1;
                    end
                    if (ram_rdy) begin
                        issued <= 1'b0;
                        case (state)
                            // objects off this line are skipped
                            OB_READ_Y: state <= (dy < 8'd8) ? OB_READ_X : OB_NEXT;
                            OB_READ_X: state <= OB_CODE;
                            default: begin
                                rom_cs <= 1'b1;
                                state  <= OB_FETCH;
                            end
                        endcase
                    end
                end
                OB_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        nib    <= '0;
                        state  <= OB_DRAW;
                    end
                end
                OB_DRAW: begin
                    nib <= nib + 3'd1;
                    if (nib == 3'd7) begin
                        state <= OB_NEXT;
                    end
                end
                OB_NEXT: begin
                    if (idx == IW'(OBJ_COUNT - 1)) begin
                        state <= OB_IDLE;
                    end else begin
                        idx   <= idx + 1'd1;
                        state <= OB_READ_Y;
                    end
                end
                default: ;
            endcase
            if (swap) begin
                idx    <= '0;
                issued <= 1'b0;
                state  <= OB_READ_Y;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (swap) begin
            line <= vrender[7:0] ^ {8{flip}};
        end
        // y and x share the column RAM port
        if (state == OB_READ_Y && issue) begin
            y_addr <= OBJ_Y_BASE + yram_addr_t'(idx);
        end
        if (state == OB_READ_Y && ram_rdy) begin
            row <= dy[2:0];
        end
        if (state == OB_READ_X && issue) begin
            y_addr <= OBJ_X_BASE + yram_addr_t'(idx);
        end
        if (state == OB_READ_X && ram_rdy) begin
            xpos <= y_data;
        end
        if (state == OB_CODE && issue) begin
            lut_addr <= OBJ_BASE + (page ? PAGE_STEP : '0) + vram_addr_t'(idx);
        end
        if (state == OB_CODE && ram_rdy) begin
            colour   <= lut_data[15:12];
            rom_addr <= {3'b000, lut_data[11:0], row};
        end
        if (state == OB_FETCH && rom_ok) begin
            pix <= rom_data;
        end else if (state == OB_DRAW) begin
            pix <= pix >> 4;
        end
    end

    // past the right edge nothing is written
    gfx_line_buffer u_buf (
        .clk     ( clk                                    ),
        .rst     ( rst                                    ),
        .swap    ( swap                                   ),
        .wr_addr ( xn[7:0]                                ),
        .wr_data ( {colour, pix[3:0]}                     ),
        .wr_en   ( state == OB_DRAW && xn < 9'(LINE_W)    ),
        .rd_addr ( hdump[7:0]                             ),
        .rd_en   ( pxl_cen && hdump < hpos_t'(LINE_W)     ),
        .pxl     ( pxl                                    )
    );

endmodule

// ==== gfx_tilemap.sv ====
`timescale 1ns/1ps

module gfx_tilemap import kiwi_gfx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tm_cen,
    input  logic       hs,
    input  logic       flip,
    input  logic       page,
    input  hpos_t      vrender,
    // video RAM codes
    output vram_addr_t tm_addr,
    input  vram_word_t tm_data,
    // column scroll
    output yram_addr_t col_addr,
    input  logic [7:0] col_data,
    // graphics ROM
    output rom_addr_t  rom_addr,
    output logic       rom_cs,
    input  logic       rom_ok,
    input  rom_word_t  rom_data,
    // display side
    input  logic       pxl_cen,
    input  hpos_t      hdump,
    output pxl_t       pxl
);

    typedef enum logic [2:0] {
        TM_IDLE,
        TM_SCROLL,
        TM_CODE,
        TM_FETCH,
        TM_DRAW
    } tm_state_t;

    tm_state_t  state;
    logic       hs_l, swap;
    logic [1:0] cen_sr;
    logic       issued, issue, ram_rdy;
    logic [4:0] col;
    logic [2:0] nib;
    logic [7:0] line, sum;
    logic [3:0] colour;
    rom_word_t  pix;

    // new line starts on the rising edge of hs
    assign swap    = hs & ~hs_l;
    // address goes out on our cen clock
    assign issue   = tm_cen & ~issued;
    // data sits on the shared port two clocks after cen
    assign ram_rdy = cen_sr[1] & issued;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= TM_IDLE;
            hs_l   <= 1'b0;
            cen_sr <= '0;
            issued <= 1'b0;
            rom_cs <= 1'b0;
            col    <= '0;
            nib    <= '0;
        end else begin
            hs_l   <= hs;
            cen_sr <= {cen_sr[0], tm_cen};
            case (state)
                TM_SCROLL, TM_CODE: begin
                    if (issue) begin
                        issued <= 1'b1;
                    end
                    if (ram_rdy) begin
                        issued <= 1'b0;
                        if (state == TM_SCROLL) begin
                            state <= TM_CODE;
                        end else begin
                            // cs and address rise together
                            rom_cs <= 1'b1;
                            state  <= TM_FETCH;
                        end
                    end
                end
                TM_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        nib    <= '0;
                        state  <= TM_DRAW;
                    end
                end
                TM_DRAW: begin
                    nib <= nib + 3'd1;
                    if (nib == 3'd7) begin
                        if (col == 5'(TILE_COLS - 1)) begin
                            state <= TM_IDLE;
                        end else begin
                            col   <= col + 5'd1;
                            state <= TM_SCROLL;
                        end
                    end
                end
                default: ;
            endcase
            if (swap) begin
                col    <= '0;
                issued <= 1'b0;
                state  <= TM_SCROLL;
            end
        end
    end

    always_ff @(posedge clk) begin
        // flip turns the line count upside down
        if (swap) begin
            line <= vrender[7:0] ^ {8{flip}};
        end
        if (state == TM_SCROLL && issue) begin
            col_addr <= SCROLL_BASE + yram_addr_t'(col);
        end
        if (state == TM_SCROLL && ram_rdy) begin
            sum <= line + col_data;
        end
        // 32 tiles per row, tile row is sum / 8
        if (state == TM_CODE && issue) begin
            tm_addr <= TM_BASE + (page ? PAGE_STEP : '0) + vram_addr_t'({sum[7:3], col});
        end
        if (state == TM_CODE && ram_rdy) begin
            colour   <= tm_data[15:12];
            rom_addr <= {3'b000, tm_data[11:0], sum[2:0]};
        end
        // pixels leave from the low nibble
        if (state == TM_FETCH && rom_ok) begin
            pix <= rom_data;
        end else if (state == TM_DRAW) begin
            pix <= pix >> 4;
        end
    end

    gfx_line_buffer u_buf (
        .clk     ( clk                                    ),
        .rst     ( rst                                    ),
        .swap    ( swap                                   ),
        .wr_addr ( {col, nib}                             ),
        .wr_data ( {colour, pix[3:0]}                     ),
        .wr_en   ( state == TM_DRAW                       ),
        .rd_addr ( hdump[7:0]                             ),
        .rd_en   ( pxl_cen && hdump < hpos_t'(LINE_W)     ),
        .pxl     ( pxl                                    )
    );

endmodule

// ==== gfx_line_buffer.sv ====
`timescale 1ns/1ps

module gfx_line_buffer import kiwi_gfx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       swap,
    // renderer side, back half
    input  logic [7:0] wr_addr,
    input  pxl_t       wr_data,
    input  logic       wr_en,
    // display side, front half
    input  logic [7:0] rd_addr,
    input  logic       rd_en,
    output pxl_t       pxl
);

    pxl_t mem [0:1][0:255];
    // selects the front half
    logic half;
    logic wr_ok;

    // first opaque pixel stays, later ones and blanks are dropped
    assign wr_ok = wr_en && wr_data[3:0] != 4'd0 && mem[~half][wr_addr][3:0] == 4'd0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            half <= 1'b0;
            pxl  <= '0;
            for (int h = 0; h < 2; h++) begin
                for (int i = 0; i < 256; i++) begin
                    mem[h][i] <= '0;
                end
            end
        end else begin
            if (swap) begin
                half <= ~half;
            end
            if (rd_en) begin
                pxl <= mem[half][rd_addr];
            end
            for (int h = 0; h < 2; h++) begin
                if (h == int'(half)) begin
                    // clear behind the read so the half comes back empty
                    if (rd_en) begin
                        mem[h][rd_addr] <= '0;
                    end
                end else if (wr_ok) begin
                    mem[h][wr_addr] <= wr_data;
                end
            end
        end
    end

endmodule

// ==== gfx_dual_ram.sv ====
`timescale 1ns/1ps

module gfx_dual_ram #(
    parameter int AW = 10,
    parameter int DW = 8
) (
    input  logic              clk,
    // port 0, cpu side
    input  logic [AW-1:0]     addr0,
    input  logic [DW-1:0]     data0,
    input  logic [DW/8-1:0]   we0,
    output logic [DW-1:0]     q0,
    // port 1, read only, renderers
    input  logic [AW-1:0]     addr1,
    output logic [DW-1:0]     q1
);

    logic [DW-1:0] mem [0:2**AW-1];

    always_ff @(posedge clk) begin
        // byte lanes written one by one
        for (int b = 0; b < DW/8; b++) begin
            if (we0[b]) begin
                mem[addr0][8*b +: 8] <= data0[8*b +: 8];
            end
        end
        // registered reads, old data on a write
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

// ==== kiwi_gfx_pkg.sv ====
package kiwi_gfx_pkg;

    // video RAM word address, 4k words
    typedef logic [11:0] vram_addr_t;
    // high byte is {colour, code[11:8]}, low byte is code[7:0]
    typedef logic [15:0] vram_word_t;
    // column RAM byte address
    typedef logic [9:0]  yram_addr_t;
    // ROM word address {3'b0, code, row}
    typedef logic [17:0] rom_addr_t;
    // 8 pixels of 4 bits, pixel 0 in the low nibble
    typedef logic [31:0] rom_word_t;
    // {colour, value}, value 0 is transparent
    typedef logic [7:0]  pxl_t;
    // horizontal and vertical counters
    typedef logic [8:0]  hpos_t;

    // video RAM map
    localparam vram_addr_t TM_BASE   = 12'h000;
    localparam vram_addr_t OBJ_BASE  = 12'h800;
    // added when a page bit is set
    localparam vram_addr_t PAGE_STEP = 12'h400;

    // column RAM map
    localparam yram_addr_t OBJ_Y_BASE  = 10'h000;
    localparam yram_addr_t OBJ_X_BASE  = 10'h100;
    // one scroll byte per tile column
    localparam yram_addr_t SCROLL_BASE = 10'h200;

    // line geometry
    localparam int LINE_W    = 256;
    localparam int TILE_COLS = 32;

endpackage
